//--- project.f
+incdir+tb
rtl/bexkat_isa_pkg.sv
rtl/bexkat_bus_pkg.sv
rtl/bexkat_alu.sv
rtl/bexkat_regfile.sv
rtl/bexkat_bus_port.sv
rtl/bexkat_sequencer.sv
rtl/bexkat_core.sv
tb/tb_clock_gen.sv
tb/bexkat_bus_sva.sv
tb/tb_bexkat.sv

//--- rtl/bexkat_alu.sv
`timescale 1ns/10ps

module bexkat_alu (
  input  bexkat_isa_pkg::word_t     a,
  input  bexkat_isa_pkg::word_t     b,
  input  bexkat_isa_pkg::alu_func_e func,
  output bexkat_isa_pkg::word_t     result,
  output bexkat_isa_pkg::ccr_t      flags
);
  import bexkat_isa_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;
  logic        carry;
  logic        overflow;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b}; // bit 32 is the borrow

  always_comb begin
    carry    = 1'b0;
    overflow = 1'b0;
    case (func)
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_add: begin
        result   = sum[31:0];
        carry    = sum[32];
        overflow = (a[31] == b[31]) && (result[31] != a[31]);
      end
      alu_sub: begin
        result   = diff[31:0];
        carry    = diff[32];
        overflow = (a[31] != b[31]) && (result[31] != a[31]);
      end
      alu_xor: result = a ^ b;
      alu_shl: result = a << b[4:0];
      alu_shr: result = a >> b[4:0];
      default: result = '0;
    endcase
    flags = '{
      carry:    carry,
      negative: result[31],
      overflow: overflow,
      zero:     (result == '0)
    };
  end

endmodule

//--- rtl/bexkat_bus_pkg.sv
package bexkat_bus_pkg;

  typedef logic [31:0] bus_addr_t; // byte address
  typedef logic [15:0] bus_data_t;

  typedef struct packed {
    bus_addr_t address;
    logic      read;
    logic      write;
    bus_data_t writedata;
  } bus_req_t;

  typedef struct packed {
    logic      done; // one cycle per transfer
    bus_data_t readdata;
  } bus_rsp_t;

  localparam bus_addr_t default_reset_pc = 32'hffc0_0000; // monitor base

endpackage

//--- rtl/bexkat_bus_port.sv
`timescale 1ns/10ps

module bexkat_bus_port (
  input  logic                      csi_clk,
  input  logic                      rsi_reset_n,
  input  logic                      start,
  input  bexkat_bus_pkg::bus_req_t  req,
  input  logic                      avm_m0_waitrequest,
  input  bexkat_bus_pkg::bus_data_t avm_m0_readdata,
  output bexkat_bus_pkg::bus_rsp_t  rsp,
  output bexkat_bus_pkg::bus_addr_t avm_m0_address,
  output logic                      avm_m0_read,
  output logic                      avm_m0_write,
  output bexkat_bus_pkg::bus_data_t avm_m0_writedata,
  output logic [1:0]                avm_m0_byteenable
);
  import bexkat_bus_pkg::*;

  logic      done_q;
  bus_data_t rdata_q;
  logic      complete;

  assign complete          = (avm_m0_read || avm_m0_write) && !avm_m0_waitrequest;
  assign avm_m0_byteenable = (avm_m0_read || avm_m0_write) ? 2'b11 : 2'b00;
  assign rsp               = '{done: done_q, readdata: rdata_q};

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      avm_m0_read  <= 1'b0;
      avm_m0_write <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_q <= complete;
      if (start) begin
        avm_m0_read  <= req.read;
        avm_m0_write <= req.write;
      end else if (complete) begin
        avm_m0_read  <= 1'b0;
        avm_m0_write <= 1'b0;
      end
    end
  end

  always_ff @(posedge csi_clk) begin
    if (start) begin
      avm_m0_address   <= req.address;
      avm_m0_writedata <= req.writedata;
    end
    if (complete)
      rdata_q <= avm_m0_readdata; // sampled on the completing edge
  end

endmodule

//--- rtl/bexkat_core.sv
`timescale 1ns/10ps

module bexkat_core #(
  parameter bexkat_bus_pkg::bus_addr_t reset_pc = bexkat_bus_pkg::default_reset_pc
) (
  input  logic                      csi_clk,
  input  logic                      rsi_reset_n,
  input  logic                      avm_m0_waitrequest,
  input  bexkat_bus_pkg::bus_data_t avm_m0_readdata,
  output bexkat_bus_pkg::bus_addr_t avm_m0_address,
  output logic                      avm_m0_read,
  output logic                      avm_m0_write,
  output bexkat_bus_pkg::bus_data_t avm_m0_writedata,
  output logic [1:0]                avm_m0_byteenable
);
  import bexkat_isa_pkg::*;
  import bexkat_bus_pkg::*;

  logic      start;
  bus_req_t  req;
  bus_rsp_t  rsp;
  reg_addr_t rd_addr1;
  reg_addr_t rd_addr2;
  reg_addr_t wr_addr;
  logic      wr_en;
  word_t     wr_data;
  word_t     rd_data1;
  word_t     rd_data2;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  alu_func_e alu_func;
  ccr_t      alu_flags;

  bexkat_sequencer #(
    .reset_pc(reset_pc)
  ) seq_i (
    .csi_clk, .rsi_reset_n, .rsp, .rd_data1, .rd_data2, .alu_result, .alu_flags,
    .start, .req, .rd_addr1, .rd_addr2, .wr_en, .wr_addr, .wr_data,
    .alu_a, .alu_b, .alu_func
  );

  bexkat_bus_port bus_i (
    .csi_clk, .rsi_reset_n, .start, .req, .avm_m0_waitrequest, .avm_m0_readdata,
    .rsp, .avm_m0_address, .avm_m0_read, .avm_m0_write, .avm_m0_writedata,
    .avm_m0_byteenable
  );

  bexkat_alu alu_i (
    .a(alu_a), .b(alu_b), .func(alu_func), .result(alu_result), .flags(alu_flags)
  );

  bexkat_regfile regs_i (
    .csi_clk, .rsi_reset_n, .rd_addr1, .rd_addr2, .wr_en, .wr_addr, .wr_data,
    .rd_data1, .rd_data2
  );

endmodule

//--- rtl/bexkat_isa_pkg.sv
package bexkat_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [2:0] {
    mode_regind = 3'd2,
    mode_reg    = 3'd3,
    mode_inh    = 3'd4,
    mode_imm    = 3'd5
  } ir_mode_e;

  typedef enum logic [2:0] {
    op_nop = 3'd0,
    op_cmp = 3'd2, // flags only
    op_inc = 3'd3,
    op_dec = 3'd4,
    op_mov = 3'd7
  } inh_op_e;

  typedef enum logic [2:0] {
    op_bra  = 3'd0,
    op_beq  = 3'd1,
    op_bne  = 3'd2,
    op_blt  = 3'd3,
    op_bge  = 3'd4,
    op_ldis = 3'd7
  } imm_op_e;

  typedef enum logic [2:0] {
    op_st = 3'd2,
    op_ld = 3'd3
  } mem_op_e;

  typedef enum logic [3:0] {
    alu_and = 4'd0,
    alu_or  = 4'd1,
    alu_add = 4'd2,
    alu_sub = 4'd3,
    alu_xor = 4'd4,
    alu_shl = 4'd5,
    alu_shr = 4'd6 // logical
  } alu_func_e;

  typedef struct packed {
    logic carry; // borrow on sub
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

  typedef struct packed {
    ir_mode_e  mode;
    logic [2:0] op;
    reg_addr_t rb;
    reg_addr_t ra;
  } ir_head_t;

  // second halfword, read per mode
  typedef union packed {
    struct packed {
      alu_func_e func;
      logic [6:0] pad;
      reg_addr_t rc;
    } alu_view;
    logic [15:0] imm_view;
  } ir_ext_u;

endpackage

//--- rtl/bexkat_regfile.sv
`timescale 1ns/10ps

module bexkat_regfile (
  input  logic                      csi_clk,
  input  logic                      rsi_reset_n,
  input  bexkat_isa_pkg::reg_addr_t rd_addr1,
  input  bexkat_isa_pkg::reg_addr_t rd_addr2,
  input  logic                      wr_en,
  input  bexkat_isa_pkg::reg_addr_t wr_addr,
  input  bexkat_isa_pkg::word_t     wr_data,
  output bexkat_isa_pkg::word_t     rd_data1,
  output bexkat_isa_pkg::word_t     rd_data2
);
  import bexkat_isa_pkg::*;

  word_t regs [32];

  // async read ports
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

//--- rtl/bexkat_sequencer.sv
`timescale 1ns/10ps

module bexkat_sequencer #(
  parameter bexkat_bus_pkg::bus_addr_t reset_pc = bexkat_bus_pkg::default_reset_pc
) (
  input  logic                       csi_clk,
  input  logic                       rsi_reset_n,
  input  bexkat_bus_pkg::bus_rsp_t   rsp,
  input  bexkat_isa_pkg::word_t      rd_data1,
  input  bexkat_isa_pkg::word_t      rd_data2,
  input  bexkat_isa_pkg::word_t      alu_result,
  input  bexkat_isa_pkg::ccr_t       alu_flags,
  output logic                       start,
  output bexkat_bus_pkg::bus_req_t   req,
  output bexkat_isa_pkg::reg_addr_t  rd_addr1,
  output bexkat_isa_pkg::reg_addr_t  rd_addr2,
  output logic                       wr_en,
  output bexkat_isa_pkg::reg_addr_t  wr_addr,
  output bexkat_isa_pkg::word_t      wr_data,
  output bexkat_isa_pkg::word_t      alu_a,
  output bexkat_isa_pkg::word_t      alu_b,
  output bexkat_isa_pkg::alu_func_e  alu_func
);
  import bexkat_isa_pkg::*;
  import bexkat_bus_pkg::*;

  typedef enum logic [2:0] {
    s_fetch_head,
    s_eval_head,
    s_fetch_ext,
    s_eval_ext,
    s_mem_wait
  } state_e;

  state_e    state;
  logic      pending; // fetch issued, waiting for done
  bus_addr_t pc;
  ir_head_t  head;
  ir_ext_u   ext;
  bus_addr_t mar;
  bus_data_t mdr;
  ccr_t      ccr;
  word_t     imm_sext;
  logic      fetch_done;
  logic      mem_phase;
  logic      is_mem;
  logic      is_store;
  logic      take_branch;

  assign imm_sext   = {{16{ext.imm_view[15]}}, ext.imm_view};
  assign fetch_done = pending && rsp.done;
  assign mem_phase  = (state == s_mem_wait);
  assign is_store   = (head.mode == mode_regind) && (mem_op_e'(head.op) == op_st);
  assign is_mem     = is_store || ((head.mode == mode_regind) && (mem_op_e'(head.op) == op_ld));

  always_comb begin
    case (imm_op_e'(head.op))
      op_bra:  take_branch = 1'b1;
      op_beq:  take_branch = ccr.zero;
      op_bne:  take_branch = !ccr.zero;
      op_blt:  take_branch = (ccr.negative != ccr.overflow);
      op_bge:  take_branch = (ccr.negative == ccr.overflow);
      default: take_branch = 1'b0; // ldis
    endcase
  end

  // only sampled by the bus port while start is high
  assign req = '{
    address:   mem_phase ? mar : pc,
    read:      !(mem_phase && is_store),
    write:     mem_phase && is_store,
    writedata: mdr
  };

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state   <= s_fetch_head;
      pending <= 1'b0;
      start   <= 1'b0;
      pc      <= reset_pc;
      ccr     <= '0;
    end else begin
      start <= 1'b0;
      case (state)
        s_fetch_head, s_fetch_ext: begin
          if (!pending) begin
            start   <= 1'b1;
            pending <= 1'b1;
          end else if (rsp.done) begin
            pending <= 1'b0;
            pc      <= pc + 32'd2;
            state   <= (state == s_fetch_head) ? s_eval_head : s_eval_ext;
          end
        end
        s_eval_head: begin
          case (head.mode)
            mode_reg, mode_imm, mode_regind: state <= s_fetch_ext;
            default: begin
              if (head.mode == mode_inh && inh_op_e'(head.op) == op_cmp)
                ccr <= alu_flags;
              state <= s_fetch_head; // unknown modes fall through as nop
            end
          endcase
        end
        s_eval_ext: begin
          state <= s_fetch_head;
          if (head.mode == mode_imm && take_branch)
            pc <= alu_result; // pc already past second word
          if (is_mem) begin
            start <= 1'b1;
            state <= s_mem_wait;
          end
        end
        s_mem_wait: begin
          if (rsp.done)
            state <= s_fetch_head;
        end
        default: state <= s_fetch_head;
      endcase
    end
  end

  always_ff @(posedge csi_clk) begin
    if (state == s_fetch_head && fetch_done)
      head <= ir_head_t'(rsp.readdata);
    if (state == s_fetch_ext && fetch_done)
      ext <= ir_ext_u'(rsp.readdata);
    if (state == s_eval_ext) begin
      mar <= alu_result; // rB + offset
      mdr <= rd_data2[15:0]; // low half of rA
    end
  end

  always_comb begin
    rd_addr1 = head.ra;
    rd_addr2 = head.rb;
    alu_a    = rd_data1;
    alu_b    = rd_data2;
    alu_func = alu_add;
    wr_en    = 1'b0;
    wr_addr  = head.ra;
    wr_data  = alu_result;
    case (state)
      s_eval_head: begin
        if (head.mode == mode_inh) begin
          case (inh_op_e'(head.op))
            op_cmp: alu_func = alu_sub;
            op_inc: begin
              alu_b = 32'd1;
              wr_en = 1'b1;
            end
            op_dec: begin
              alu_func = alu_sub;
              alu_b    = 32'd1;
              wr_en    = 1'b1;
            end
            op_mov: begin
              wr_data = rd_data2;
              wr_en   = 1'b1;
            end
            default: ;
          endcase
        end
      end
      s_eval_ext: begin
        case (head.mode)
          mode_reg: begin
            rd_addr1 = head.rb;
            rd_addr2 = ext.alu_view.rc;
            alu_func = ext.alu_view.func;
            wr_en    = 1'b1;
          end
          mode_imm: begin
            alu_a = pc; // branch target
            alu_b = imm_sext;
            if (imm_op_e'(head.op) == op_ldis) begin
              wr_data = imm_sext;
              wr_en   = 1'b1;
            end
          end
          mode_regind: begin
            rd_addr1 = head.rb;
            rd_addr2 = head.ra;
            alu_b    = imm_sext;
          end
          default: ;
        endcase
      end
      s_mem_wait: begin
        if (!is_store) begin
          wr_en   = rsp.done;
          wr_data = {16'h0000, rsp.readdata}; // zero extend
        end
      end
      default: ;
    endcase
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide by the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/10ps -j 0 --top-module tb_bexkat \
    -f project.f -o sim_bexkat \
  && ./obj_dir/sim_bexkat 2>&1 | tee sim.log \
  && grep -qx "PASS: all tests" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/bexkat_bus_sva.sv
`timescale 1ns/10ps

module bexkat_bus_sva (
  input logic                      csi_clk,
  input logic                      rsi_reset_n,
  input logic                      avm_m0_waitrequest,
  input logic                      avm_m0_read,
  input logic                      avm_m0_write,
  input bexkat_bus_pkg::bus_addr_t avm_m0_address,
  input bexkat_bus_pkg::bus_data_t avm_m0_writedata,
  input logic [1:0]                avm_m0_byteenable
);

  one_strobe: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    !(avm_m0_read && avm_m0_write))
    else $error("read and write strobes high together");

  hold_on_wait: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    (avm_m0_waitrequest && (avm_m0_read || avm_m0_write)) |=>
      ($stable(avm_m0_address) && $stable(avm_m0_read) && $stable(avm_m0_write)
        && $stable(avm_m0_writedata)))
    else $error("bus outputs changed while waitrequest was high");

  full_width: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    (avm_m0_read || avm_m0_write) |-> (avm_m0_byteenable == 2'b11))
    else $error("byte enable not 11 during a transfer");

  idle_after_reset: assert property (@(posedge csi_clk)
    $rose(rsi_reset_n) |=> !(avm_m0_read || avm_m0_write))
    else $error("strobe high in the cycle after reset release");

endmodule

bind bexkat_bus_port bexkat_bus_sva bus_sva_i (.*);

//--- tb/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

typedef struct packed {
  logic [15:0][15:0] prog; // halfword 0 in the top bits
  bus_addr_t         addr; // expected store address
  bus_data_t         data; // expected store data
} program_entry_t;

localparam int num_programs = 19;

// program halfwords 0..15, then store address and store data
// branch rows set r1 and r2 by ldis, then cmp r1 r2, inc r3, branch +2, inc r3, st r3
localparam program_entry_t programs [num_programs] = '{
  '{256'hBC018001BC0201804841FFF0A000FFFC00000000000000000000000000000000, 32'h170, 16'h8001},
  '{256'hBC017000BC0230006023200248030100A000FFFC000000000000000000000000, 32'h100, 16'hA000},
  '{256'hBC010005BC0200096023300248030100A000FFFC000000000000000000000000, 32'h100, 16'hFFFC},
  '{256'hBC015A5ABC020FF06023400248030100A000FFFC000000000000000000000000, 32'h100, 16'h55AA},
  '{256'hBC010123BC0200246023500248030100A000FFFC000000000000000000000000, 32'h100, 16'h1230},
  '{256'hBC05135780009CA38C038C03900348030100A000FFFC00000000000000000000, 32'h100, 16'h1358},
  '{256'hBC0200104C44000C48040100A000FFFC000000000000000000000000C3A50000, 32'h100, 16'hC3A5},
  '{256'hBC010005BC02000588418C03A40000028C0348030100A000FFFC000000000000, 32'h100, 16'h0001},
  '{256'hBC01FFFEBC02000388418C03A40000028C0348030100A000FFFC000000000000, 32'h100, 16'h0002},
  '{256'hBC010003BC02FFFE88418C03A40000028C0348030100A000FFFC000000000000, 32'h100, 16'h0002},
  '{256'hBC010005BC02000588418C03A80000028C0348030100A000FFFC000000000000, 32'h100, 16'h0002},
  '{256'hBC01FFFEBC02000388418C03A80000028C0348030100A000FFFC000000000000, 32'h100, 16'h0001},
  '{256'hBC010003BC02FFFE88418C03A80000028C0348030100A000FFFC000000000000, 32'h100, 16'h0001},
  '{256'hBC010005BC02000588418C03AC0000028C0348030100A000FFFC000000000000, 32'h100, 16'h0002},
  '{256'hBC01FFFEBC02000388418C03AC0000028C0348030100A000FFFC000000000000, 32'h100, 16'h0001},
  '{256'hBC010003BC02FFFE88418C03AC0000028C0348030100A000FFFC000000000000, 32'h100, 16'h0002},
  '{256'hBC010005BC02000588418C03B00000028C0348030100A000FFFC000000000000, 32'h100, 16'h0001},
  '{256'hBC01FFFEBC02000388418C03B00000028C0348030100A000FFFC000000000000, 32'h100, 16'h0002},
  '{256'hBC010003BC02FFFE88418C03B00000028C0348030100A000FFFC000000000000, 32'h100, 16'h0001}
};

`endif

//--- tb/tb_bexkat.sv
`timescale 1ns/10ps

module tb_bexkat;
  import bexkat_isa_pkg::*;
  import bexkat_bus_pkg::*;

  `include "tb_programs.svh"

  localparam int seed        = 9269;
  localparam int cycle_limit = num_programs * 16 * 5 * 2; // entries x halfwords x cycles x 2

  logic       csi_clk;
  logic       por_n;
  logic       run_reset_n;
  logic       rsi_reset_n;
  logic       avm_m0_waitrequest;
  bus_data_t  avm_m0_readdata;
  bus_addr_t  avm_m0_address;
  logic       avm_m0_read;
  logic       avm_m0_write;
  bus_data_t  avm_m0_writedata;
  logic [1:0] avm_m0_byteenable;
  bus_data_t  mem [256];
  int         stall_run;
  int         cycles;

  assign rsi_reset_n     = por_n && run_reset_n;
  assign avm_m0_readdata = avm_m0_read ? mem[avm_m0_address[8:1]] : 16'h0000;

  tb_clock_gen #(
    .period_ns(8),
    .reset_cycles(3)
  ) clk_i (
    .clk(csi_clk),
    .reset_n(por_n)
  );

  bexkat_core #(
    .reset_pc(32'h0000_0000)
  ) dut_i (
    .*
  );

  // random stalls, at most 3 in a row
  always @(posedge csi_clk) begin
    #1;
    if (stall_run < 3 && $urandom_range(1, 0) == 1) begin
      avm_m0_waitrequest = 1'b1;
      stall_run++;
    end else begin
      avm_m0_waitrequest = 1'b0;
      stall_run = 0;
    end
  end

  always @(negedge csi_clk) begin
    if (avm_m0_write && !avm_m0_waitrequest)
      mem[avm_m0_address[8:1]] = avm_m0_writedata; // completes on next edge
  end

  always @(posedge csi_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: no store seen within %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic load_program(input program_entry_t entry);
    for (int i = 0; i < 256; i++) begin
      if (i < 16)
        mem[i] = entry.prog[15 - i];
      else
        mem[i] = 16'hd000 | 16'(i); // filler outside the program
    end
  endtask

  task automatic wait_for_store(output bus_addr_t addr, output bus_data_t data);
    @(negedge csi_clk);
    while (!(avm_m0_write && !avm_m0_waitrequest))
      @(negedge csi_clk);
    addr = avm_m0_address;
    data = avm_m0_writedata;
  endtask

  task automatic check_addr(input int n, input bus_addr_t got, input bus_addr_t exp);
    if (got !== exp) begin
      $display("ERROR %0t: program %0d stored to %h, expected %h", $time, n, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_data(input int n, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      $display("ERROR %0t: program %0d stored %h, expected %h", $time, n, got, exp);
      stop_on_failure();
    end
  endtask

  initial begin
    bus_addr_t got_addr;
    bus_data_t got_data;
    void'($urandom(seed));
    run_reset_n        = 1'b0;
    avm_m0_waitrequest = 1'b0;
    stall_run          = 0;
    cycles             = 0;
    wait (por_n);
    for (int n = 0; n < num_programs; n++) begin
      @(posedge csi_clk);
      #1;
      run_reset_n = 1'b0;
      load_program(programs[n]);
      repeat (3) @(posedge csi_clk);
      #1;
      run_reset_n = 1'b1;
      wait_for_store(got_addr, got_data);
      check_addr(n, got_addr, programs[n].addr);
      check_data(n, got_data, programs[n].data);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 reset_n = 1'b1; // release off the edge
  end

endmodule
